//--- design/nocPkg.sv
package nocPkg;

  // ports in rotation order: Local, North, East, West, South
  localparam int numPorts = 5;

  localparam int flitIdW = 3;
  localparam logic [flitIdW-1:0] idHeader = 3'd1;
  localparam logic [flitIdW-1:0] idBody   = 3'd2;
  localparam logic [flitIdW-1:0] idTail   = 3'd3;

  localparam int dataW = 32;
  localparam int flitW = flitIdW + dataW;  // id in the upper bits

  // header payload low bits hold the packet length, header included
  localparam int lenW = 12;

  localparam int bufDepth = 4;
  localparam int bufPtrW  = 2;

  localparam int creditW = 4;  // both credit counters

  localparam logic [1:0] cfgAddrMask   = 2'd0;
  localparam logic [1:0] cfgAddrCredit = 2'd1;

  localparam logic [numPorts-1:0] defaultMask = 5'b11111;
  localparam int defaultCredit = 4;

endpackage

//--- design/flitBuffer.sv
`timescale 1ns/1ps

module flitBuffer
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     inValid,
  input  logic [nocPkg::flitW-1:0] inFlit,
  input  logic                     pop,
  output logic [nocPkg::flitW-1:0] headFlit,
  output logic                     notEmpty,
  output logic                     inCredit
);
  import nocPkg::*;

  logic [flitW-1:0]   mem [bufDepth];
  logic [bufPtrW-1:0] wrPtr;
  logic [bufPtrW-1:0] rdPtr;
  logic [bufPtrW:0]   count;
  logic               full;
  logic               doWrite;
  logic               doPop;

  assign full     = (count == (bufPtrW + 1)'(bufDepth));
  assign notEmpty = (count != '0);
  assign doWrite  = inValid && !full;  // upstream credits keep this from dropping
  assign doPop    = pop && notEmpty;
  assign headFlit = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (doWrite)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
      inCredit <= 1'b0;
    end
    else
    begin
      inCredit <= doPop;  // one credit back per popped flit
      if (doWrite)
        wrPtr <= wrPtr + 1'b1;  // depth is a power of two, wraps
      if (doPop)
        rdPtr <= rdPtr + 1'b1;
      case ({doWrite, doPop})
        2'b10:
          count <= count + 1'b1;
        2'b01:
          count <= count - 1'b1;
        default:
          count <= count;
      endcase
    end
  end

endmodule

//--- design/holdTimer.sv
`timescale 1ns/1ps

module holdTimer
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic [nocPkg::flitW-1:0] headFlit,
  input  logic                     advance,
  output logic                     packetDone
);
  import nocPkg::*;

  logic [lenW-1:0] pktLen;
  logic [lenW-1:0] flitCnt;  // flits of this packet already granted
  logic [lenW-1:0] headLen;
  logic            isHeader;

  assign isHeader = (headFlit[flitW-1 -: flitIdW] == idHeader);
  assign headLen  = headFlit[lenW-1:0];

  always_comb
  begin
    if (!advance)
      packetDone = 1'b0;
    else if (isHeader)
      packetDone = (headLen <= lenW'(1));  // single-flit packet
    else
      packetDone = (flitCnt + 1'b1 == pktLen);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pktLen  <= '0;
      flitCnt <= '0;
    end
    else if (advance)
    begin
      if (isHeader)
      begin
        pktLen  <= headLen;
        flitCnt <= lenW'(1);
      end
      else
        flitCnt <= flitCnt + 1'b1;
    end
  end

endmodule

//--- design/outputArbiter.sv
`timescale 1ns/1ps

module outputArbiter
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic [nocPkg::numPorts-1:0] reqs,
  input  logic [nocPkg::numPorts-1:0] portMask,
  input  logic [nocPkg::flitW-1:0]    headFlits [nocPkg::numPorts],
  input  logic                        canSend,
  output logic [nocPkg::numPorts:0]   grant,
  output logic [nocPkg::numPorts-1:0] pops
);
  import nocPkg::*;

  logic [numPorts:0]   nextGrant;
  logic [numPorts-1:0] eligible;
  logic [numPorts-1:0] packetDone;
  int                  holder;
  int                  pick;

  assign eligible = reqs & portMask;  // mask only matters at grant time
  assign pops     = grant[numPorts:1] & reqs & {numPorts{canSend}};

  for (genvar p = 0; p < numPorts; p++)
  begin : genTimer
    holdTimer timer_i
    (
      .clk        (clk),
      .rst        (rst),
      .headFlit   (headFlits[p]),
      .advance    (pops[p]),
      .packetDone (packetDone[p])
    );
  end

  always_comb
  begin
    holder = 0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i + 1])
        holder = i;
    end
  end

  // first eligible input in rotation, holder itself excluded
  always_comb
  begin
    pick = -1;
    if (grant[0])
    begin
      for (int i = numPorts - 1; i >= 0; i--)
      begin
        if (eligible[i])
          pick = i;
      end
    end
    else
    begin
      for (int k = numPorts - 1; k >= 1; k--)
      begin
        if (eligible[(holder + k) % numPorts])
          pick = (holder + k) % numPorts;
      end
    end
  end

  always_comb
  begin
    nextGrant = grant;  // held until the tail goes out
    if (grant[0] || (|packetDone))
    begin
      nextGrant = '0;
      if (pick < 0)
        nextGrant[0] = 1'b1;
      else
        nextGrant[pick + 1] = 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= (numPorts + 1)'(1);  // idle
    else
      grant <= nextGrant;
  end

endmodule

//--- design/arbConfig.sv
`timescale 1ns/1ps

module arbConfig
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        cfgWe,
  input  logic [1:0]                  cfgAddr,
  input  logic [7:0]                  cfgWdata,
  output logic [7:0]                  cfgRdata,
  output logic [nocPkg::numPorts-1:0] portMask,
  output logic [nocPkg::creditW-1:0]  creditInit,
  output logic                        creditLoad
);
  import nocPkg::*;

  logic [numPorts-1:0] maskReg;
  logic [creditW-1:0]  creditReg;
  logic                wrMask;
  logic                wrCredit;

  assign wrMask     = cfgWe && (cfgAddr == cfgAddrMask);
  assign wrCredit   = cfgWe && (cfgAddr == cfgAddrCredit);
  assign portMask   = maskReg;
  assign creditInit = creditReg;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      maskReg    <= defaultMask;
      creditReg  <= creditW'(defaultCredit);
      creditLoad <= 1'b0;
    end
    else
    begin
      creditLoad <= wrCredit;  // output stage reloads on the next edge
      if (wrMask)
        maskReg <= cfgWdata[numPorts-1:0];
      if (wrCredit)
        creditReg <= cfgWdata[creditW-1:0];
    end
  end

  always_comb
  begin
    case (cfgAddr)
      cfgAddrMask:
        cfgRdata = 8'(maskReg);
      cfgAddrCredit:
        cfgRdata = 8'(creditReg);
      default:
        cfgRdata = '0;
    endcase
  end

endmodule

//--- design/outputStage.sv
`timescale 1ns/1ps

module outputStage
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic [nocPkg::numPorts:0]  grant,
  input  logic [nocPkg::flitW-1:0]   headFlits [nocPkg::numPorts],
  input  logic                       advance,
  input  logic                       creditIn,
  input  logic [nocPkg::creditW-1:0] creditInit,
  input  logic                       creditLoad,
  output logic                       canSend,
  output logic                       outValid,
  output logic [nocPkg::flitW-1:0]   outFlit
);
  import nocPkg::*;

  logic [flitW-1:0]   selFlit;
  logic [creditW-1:0] creditCnt;  // downstream buffer slots still free

  always_comb
  begin
    selFlit = '0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i + 1])
        selFlit = headFlits[i];
    end
  end

  assign canSend = (creditCnt != '0);

  always_ff @(posedge clk)
  begin
    if (advance)
      outFlit <= selFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid  <= 1'b0;
      creditCnt <= creditW'(defaultCredit);
    end
    else
    begin
      outValid <= advance;
      if (creditLoad)
        creditCnt <= creditInit;
      else
        creditCnt <= creditCnt + creditW'(creditIn) - creditW'(advance);  // both may hit at once
    end
  end

endmodule

//--- design/routerOutPort.sv
`timescale 1ns/1ps

module routerOutPort
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic [nocPkg::numPorts-1:0] inValid,
  input  logic [nocPkg::flitW-1:0]    inFlit [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0] inCredit,
  output logic                        outValid,
  output logic [nocPkg::flitW-1:0]    outFlit,
  input  logic                        creditIn,
  input  logic                        cfgWe,
  input  logic [1:0]                  cfgAddr,
  input  logic [7:0]                  cfgWdata,
  output logic [7:0]                  cfgRdata
);
  import nocPkg::*;

  logic [numPorts-1:0] bufNotEmpty;
  logic [flitW-1:0]    headFlits [numPorts];
  logic [numPorts-1:0] pops;
  logic [numPorts:0]   grant;
  logic [numPorts-1:0] portMask;
  logic [creditW-1:0]  creditInit;
  logic                creditLoad;
  logic                canSend;

  for (genvar p = 0; p < numPorts; p++)
  begin : genBuf
    flitBuffer buf_i
    (
      .clk      (clk),
      .rst      (rst),
      .inValid  (inValid[p]),
      .inFlit   (inFlit[p]),
      .pop      (pops[p]),
      .headFlit (headFlits[p]),
      .notEmpty (bufNotEmpty[p]),
      .inCredit (inCredit[p])
    );
  end

  outputArbiter arb_i
  (
    .clk       (clk),
    .rst       (rst),
    .reqs      (bufNotEmpty),
    .portMask  (portMask),
    .headFlits (headFlits),
    .canSend   (canSend),
    .grant     (grant),
    .pops      (pops)
  );

  arbConfig cfg_i
  (
    .clk        (clk),
    .rst        (rst),
    .cfgWe      (cfgWe),
    .cfgAddr    (cfgAddr),
    .cfgWdata   (cfgWdata),
    .cfgRdata   (cfgRdata),
    .portMask   (portMask),
    .creditInit (creditInit),
    .creditLoad (creditLoad)
  );

  outputStage out_i
  (
    .clk        (clk),
    .rst        (rst),
    .grant      (grant),
    .headFlits  (headFlits),
    .advance    (|pops),  // at most one pop per cycle
    .creditIn   (creditIn),
    .creditInit (creditInit),
    .creditLoad (creditLoad),
    .canSend    (canSend),
    .outValid   (outValid),
    .outFlit    (outFlit)
  );

endmodule

//--- verif/clkGen.sv
`timescale 1ns/1ps

module clkGen
(
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  initial
  begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- verif/routerOutPort_assert.sv
`timescale 1ns/1ps

module routerOutPort_assert
(
  input logic                        clk,
  input logic                        rst,
  input logic [nocPkg::numPorts:0]   grant,
  input logic [nocPkg::numPorts-1:0] pops,
  input logic [nocPkg::numPorts-1:0] inValid,
  input logic                        creditIn,
  input logic [nocPkg::creditW-1:0]  creditInit,
  input logic                        outValid,
  input logic [nocPkg::flitW-1:0]    outFlit
);
  import nocPkg::*;

  int                 failCount = 0;
  logic [flitIdW-1:0] outId;
  logic               lastFlit;
  logic [creditW:0]   inFlight;  // sent downstream, credit not yet back

  assign outId    = outFlit[flitW-1 -: flitIdW];
  assign lastFlit = (outId == idTail) || (outId == idHeader && outFlit[lenW-1:0] <= lenW'(1));

  for (genvar p = 0; p < numPorts; p++)
  begin : genOcc
    logic [bufPtrW:0] occ;  // modeled fill of buffer p

    always_ff @(posedge clk)
    begin
      if (rst)
        occ <= '0;
      else
        occ <= occ + (bufPtrW + 1)'(inValid[p]) - (bufPtrW + 1)'(pops[p]);
    end

    assert property (@(posedge clk) disable iff (rst)
      !(inValid[p] && occ == (bufPtrW + 1)'(bufDepth)))
      else
      begin
        $error("input %0d written while its buffer is full", p);
        failCount++;
      end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      inFlight <= '0;
    else
      inFlight <= inFlight + (creditW + 1)'(outValid) - (creditW + 1)'(creditIn);
  end

  assert property (@(posedge clk) disable iff (rst) $onehot(grant))
    else
    begin
      $error("grant is not one-hot");
      failCount++;
    end

  // every flit out needs a downstream slot not already taken
  assert property (@(posedge clk) disable iff (rst)
    outValid |-> (inFlight < (creditW + 1)'(creditInit)))
    else
    begin
      $error("flit sent with no downstream credit");
      failCount++;
    end

  // a held grant may only move right after the last flit of its packet
  assert property (@(posedge clk) disable iff (rst)
    (!$past(grant[0]) && grant != $past(grant)) |-> (outValid && lastFlit))
    else
    begin
      $error("grant moved in the middle of a packet");
      failCount++;
    end

endmodule

//--- verif/tbRouterOutPort.sv
`timescale 1ns/1ps

module tbRouterOutPort;
  import nocPkg::*;

  localparam int maxRecs     = 64;
  localparam int stallTest   = 3;  // downstream withholds credits at first
  localparam int stallCycles = 30;
  localparam int maskTest    = 5;
  localparam int maskedPort  = 2;  // East

  logic                clk;
  logic                rst;
  logic [numPorts-1:0] inValid;
  logic [flitW-1:0]    inFlit [numPorts];
  logic [numPorts-1:0] inCredit;
  logic                outValid;
  logic [flitW-1:0]    outFlit;
  logic                creditIn;
  logic                cfgWe;
  logic [1:0]          cfgAddr;
  logic [7:0]          cfgWdata;
  logic [7:0]          cfgRdata;

  int               recTest [maxRecs];
  int               recPort [maxRecs];
  int               recLen  [maxRecs];
  int               recPos  [maxRecs];
  logic [dataW-1:0] recBase [maxRecs];
  int               numRecs;

  logic [flitW-1:0] portQ [numPorts][$];  // flits each upstream still has to send
  logic [flitW-1:0] expQ [$];
  longint           retQ [$];  // cycle at which downstream frees a slot
  int               upCredits [numPorts];
  int               sentCnt   [numPorts];
  int               creditCnt [numPorts];
  longint           cycle      = 0;
  longint           cycleLimit = 64'd1_000_000;
  int               rcvCnt;
  int               returnedTotal;
  int               creditBase;
  int               errors;
  int               checks;
  bit               withhold;

  clkGen clkGen_i
  (
    .clk (clk),
    .rst (rst)
  );

  routerOutPort dut_i
  (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inFlit   (inFlit),
    .inCredit (inCredit),
    .outValid (outValid),
    .outFlit  (outFlit),
    .creditIn (creditIn),
    .cfgWe    (cfgWe),
    .cfgAddr  (cfgAddr),
    .cfgWdata (cfgWdata),
    .cfgRdata (cfgRdata)
  );

  bind routerOutPort routerOutPort_assert assert_i
  (
    .clk        (clk),
    .rst        (rst),
    .grant      (grant),
    .pops       (pops),
    .inValid    (inValid),
    .creditIn   (creditIn),
    .creditInit (creditInit),
    .outValid   (outValid),
    .outFlit    (outFlit)
  );

  task automatic checkVal(input string name, input logic [63:0] actual,
                          input logic [63:0] expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("Fail at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  // header carries the length in its low bits, the rest carry base plus index
  function automatic logic [flitW-1:0] makeFlit(input logic [dataW-1:0] base, input int len,
                                                input int idx);
    logic [flitIdW-1:0] id;
    logic [dataW-1:0]   data;
    id   = (idx == 0) ? idHeader : ((idx == len - 1) ? idTail : idBody);
    data = (idx == 0) ? base + dataW'(len) : base + dataW'(idx);
    return {id, data};
  endfunction

  task automatic readTestData();
    int    fd;
    string line;
    numRecs = 0;
    fd = $fopen("verif/routerOutPort_testdata.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("could not open the test data file");
    end
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        if (line.len() > 1 && line.getc(0) != "#" && numRecs < maxRecs)
        begin
          if ($sscanf(line, "%d %d %d %h %d", recTest[numRecs], recPort[numRecs],
                      recLen[numRecs], recBase[numRecs], recPos[numRecs]) == 5)
            numRecs++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic writeConfig(input logic [1:0] addr, input logic [7:0] data);
    @(posedge clk);
    cfgWe    <= 1'b1;
    cfgAddr  <= addr;
    cfgWdata <= data;
    @(posedge clk);
    cfgWe <= 1'b0;
  endtask

  task automatic readConfig(input logic [1:0] addr, input logic [7:0] expected,
                            input string name);
    @(posedge clk);
    cfgAddr <= addr;
    @(negedge clk);
    checkVal(name, cfgRdata, expected);
  endtask

  task automatic runTest(input int t);
    int         total;
    int         maskedFlits;
    int         errsBefore;
    logic [7:0] maskOff;
    errsBefore  = errors;
    total       = 0;
    maskedFlits = 0;
    maskOff     = 8'(defaultMask) & ~(8'h1 << maskedPort);
    @(negedge clk);
    expQ.delete();
    rcvCnt        = 0;
    returnedTotal = 0;
    creditBase    = defaultCredit;
    for (int p = 0; p < numPorts; p++)
    begin
      sentCnt[p]   = 0;
      creditCnt[p] = 0;
    end
    for (int pos = 0; pos < numRecs; pos++)  // expected order, packet by packet
    begin
      for (int i = 0; i < numRecs; i++)
      begin
        if (recTest[i] == t && recPos[i] == pos)
        begin
          for (int k = 0; k < recLen[i]; k++)
            expQ.push_back(makeFlit(recBase[i], recLen[i], k));
        end
      end
    end
    for (int i = 0; i < numRecs; i++)
    begin
      if (recTest[i] == t)
      begin
        total += recLen[i];
        if (t == maskTest && recPort[i] == maskedPort)
          maskedFlits += recLen[i];
      end
    end
    if (t == maskTest)
    begin
      writeConfig(cfgAddrMask, maskOff);
      writeConfig(cfgAddrCredit, 8'd3);
      readConfig(cfgAddrMask, maskOff, "cfgRdata mask");
      readConfig(cfgAddrCredit, 8'd3, "cfgRdata credit");
      creditBase = 3;
      @(negedge clk);
    end
    withhold = (t == stallTest);
    for (int i = 0; i < numRecs; i++)
    begin
      if (recTest[i] == t)
      begin
        for (int k = 0; k < recLen[i]; k++)
          portQ[recPort[i]].push_back(makeFlit(recBase[i], recLen[i], k));
      end
    end
    if (t == stallTest)
    begin
      repeat (stallCycles) @(posedge clk);
      checkVal("flits out while credits withheld", rcvCnt, creditBase);
      @(negedge clk);
      withhold = 1'b0;
    end
    if (t == maskTest)
    begin
      while (rcvCnt < total - maskedFlits)
        @(posedge clk);
      repeat (20) @(posedge clk);
      checkVal("flits out while East masked", rcvCnt, total - maskedFlits);
      writeConfig(cfgAddrMask, 8'(defaultMask));
      readConfig(cfgAddrMask, 8'(defaultMask), "cfgRdata mask");
    end
    while (rcvCnt < total || retQ.size() > 0)
      @(posedge clk);
    repeat (4) @(posedge clk);  // last upstream credits are registered
    for (int p = 0; p < numPorts; p++)
      checkVal($sformatf("inCredit[%0d] pulses", p), creditCnt[p], sentCnt[p]);
    $display("test %0d: %s, %0d flits", t, (errors == errsBefore) ? "pass" : "FAIL", total);
  endtask

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle > cycleLimit)
    begin
      $display("Timeout: flits still outstanding after %0d cycles", cycle);
      $display("Test failed");
      $finish;
    end
  end

  // upstream senders and downstream credit return
  always @(posedge clk)
  begin
    if (rst)
    begin
      inValid  <= '0;
      creditIn <= 1'b0;
    end
    else
    begin
      for (int p = 0; p < numPorts; p++)
      begin
        if (upCredits[p] > 0 && portQ[p].size() > 0)
        begin
          inValid[p] <= 1'b1;
          inFlit[p]  <= portQ[p].pop_front();
          upCredits[p]--;
          sentCnt[p]++;
        end
        else
          inValid[p] <= 1'b0;
      end
      if (!withhold && retQ.size() > 0 && retQ[0] <= cycle)
      begin
        creditIn <= 1'b1;
        retQ.delete(0);
        returnedTotal++;
      end
      else
        creditIn <= 1'b0;
    end
  end

  always @(negedge clk)
  begin
    if (!rst)
    begin
      for (int p = 0; p < numPorts; p++)
      begin
        if (inCredit[p])
        begin
          upCredits[p]++;
          creditCnt[p]++;
        end
      end
      if (outValid)
      begin
        rcvCnt++;
        retQ.push_back(cycle + 1 + ($urandom % 6));
        checkVal("credit overrun", rcvCnt > creditBase + returnedTotal, 0);
        if (expQ.size() == 0)
        begin
          errors++;
          $display("flit %0h came out at %0t after every packet was complete", outFlit, $time);
        end
        else
          checkVal("outFlit", outFlit, expQ.pop_front());
      end
    end
  end

  initial
  begin
    int total;
    int tests;
    void'($urandom(32'hbb1a_9c6a));
    inValid  = '0;
    creditIn = 1'b0;
    cfgWe    = 1'b0;
    cfgAddr  = '0;
    cfgWdata = '0;
    withhold = 1'b0;
    errors   = 0;
    checks   = 0;
    tests    = 0;
    total    = 0;
    for (int p = 0; p < numPorts; p++)
    begin
      inFlit[p]    = '0;
      upCredits[p] = bufDepth;
    end
    readTestData();
    for (int i = 0; i < numRecs; i++)
      total += recLen[i];
    cycleLimit = total * 20 + 200;
    @(negedge rst);
    for (int i = 0; i < numRecs; i++)
    begin
      if (i == 0 || recTest[i] != recTest[i - 1])
      begin
        runTest(recTest[i]);
        tests++;
      end
    end
    errors += dut_i.assert_i.failCount;  // assertion failures
    $display("%0d tests run, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0 && numRecs > 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- files.f
design/nocPkg.sv
design/flitBuffer.sv
design/holdTimer.sv
design/outputArbiter.sv
design/arbConfig.sv
design/outputStage.sv
design/routerOutPort.sv
verif/clkGen.sv
verif/routerOutPort_assert.sv
verif/tbRouterOutPort.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tbRouterOutPort
FILELIST = files.f
LOG      = sim.log
BIN      = obj_dir/V$(TOP)
PASS_MSG = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- verif/routerOutPort_testdata.txt
# test port length base(hex) position
# header data is base plus length, later flits base plus flit index
1 2 3 a0000000 0
2 0 2 10000000 0
2 1 3 11000000 1
2 2 4 12000000 2
2 3 5 13000000 3
2 4 2 14000000 4
2 0 3 20000000 5
2 4 3 24000000 6
3 1 6 30000000 0
3 3 5 33000000 1
4 0 9 40000000 0
4 2 2 42000000 1
4 4 7 44000000 2
5 0 3 50000000 0
5 1 2 51000000 1
5 2 4 52000000 4
5 3 3 53000000 2
5 4 2 54000000 3
